/* ipf.f */
+incdir+dv
rtl/ipf_pkg.sv
rtl/ipf_lcu_scan.sv
rtl/ipf_pixel_addr.sv
rtl/ipf_band_offset.sv
rtl/ipf_top.sv
dv/ipf_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ipf_tb -f ipf.f -o ipf_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/ipf_sim)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && echo "PASS" || { echo "FAIL"; exit 1; }

/* dv/ipf_ref_model.svh */
`ifndef IPF_REF_MODEL_SVH
`define IPF_REF_MODEL_SVH

// LCU side from its size code, 16 << size
function automatic int lcu_side(input int size);
    return 16 << size;
endfunction

// band rule, clamped to 0..255
function automatic int predict_pixel(input int pix, input int mode, input int band_pos,
                                     input logic [15:0] offsets);
    int band;
    int nib;
    int res;
    band = pix / 8;
    if ((mode == 0) || ((band >= band_pos - 1) && (band <= band_pos + 1))) begin
        return pix;
    end
    nib = int'((offsets >> (12 - 4 * (band % 4))) & 16'hf);    // off0 is the top nibble
    if (nib > 7) begin
        nib = nib - 16;    // 4-bit two's complement
    end
    res = pix + nib;
    if (res < 0) begin
        res = 0;
    end
    if (res > 255) begin
        res = 255;
    end
    return res;
endfunction

function automatic int predict_addr(input int row, input int col, input int lcu_x,
                                    input int lcu_y, input int size);
    int side;
    side = lcu_side(size);
    return (row + lcu_y * side) * 128 + col + lcu_x * side;
endfunction

// bottom right pixel of the bottom right LCU
function automatic bit is_frame_last(input int row, input int col, input int lcu_x,
                                     input int lcu_y, input int size);
    int side;
    int max_lcu;
    side    = lcu_side(size);
    max_lcu = 7 >> size;
    return (row == side - 1) && (col == side - 1) && (lcu_x == max_lcu) && (lcu_y == max_lcu);
endfunction

`endif

/* dv/ipf_tb.sv */
`default_nettype none

module ipf_tb;
    import ipf_pkg::*;

    `include "ipf_ref_model.svh"

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    // about 5700 beats plus ignored beats, idle gaps and reset
    localparam int CYCLE_BUDGET  = 7500;
    localparam int WATCHDOG_TIME = 2 * CYCLE_BUDGET * CLK_PERIOD;

    // what one beat should produce one cycle after it is accepted
    typedef struct packed {
        logic   acc;
        logic   last;
        pixel_t pix;
        addr_t  addr;
    } exp_t;

    logic     clk;
    logic     reset;
    logic     in_en;
    pixel_t   din;
    ipf_cfg_t cfg;
    lcu_pos_t pos;
    logic     out_en;
    pixel_t   dout;
    addr_t    dout_addr;
    logic     finish;

    exp_t exp_q[$];
    exp_t cur_exp;
    logic exp_finish;
    int   trk_row;
    int   trk_col;
    logic frame_done;
    int   mismatch_count;
    int   fail_count;

    ipf_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_en     (in_en),
        .din       (din),
        .cfg       (cfg),
        .pos       (pos),
        .out_en    (out_en),
        .dout      (dout),
        .dout_addr (dout_addr),
        .finish    (finish)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Error: watchdog timeout at %0t, the DUT did not finish in time", $time);
        $display("Simulation failed");
        $finish;
    end

    // the beat seen here was driven one edge earlier, so this is the accepting edge
    always @(posedge clk) begin
        if (reset) begin
            cur_exp    = '0;
            exp_finish = 1'b0;
        end else if (in_en) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: in_en high but no beat was recorded", $time);
                fail_count = fail_count + 1;
                cur_exp    = '0;
            end else begin
                cur_exp = exp_q.pop_front();
            end
            if (cur_exp.acc && cur_exp.last) begin
                exp_finish = 1'b1;
            end
        end else begin
            cur_exp = '0;
        end
    end

    // outputs are stable mid cycle
    always @(negedge clk) begin
        if (cur_exp.acc) begin
            assert (out_en) else begin
                $display("Error at %0t: out_en missing for an accepted beat", $time);
                fail_count = fail_count + 1;
            end
            assert (dout == cur_exp.pix) else begin
                $display("Mismatch at %0t: dout %0d, expected %0d", $time, dout, cur_exp.pix);
                mismatch_count = mismatch_count + 1;
            end
            assert (dout_addr == cur_exp.addr) else begin
                $display("Mismatch at %0t: dout_addr %0d, expected %0d",
                         $time, dout_addr, cur_exp.addr);
                mismatch_count = mismatch_count + 1;
            end
        end else begin
            assert (!out_en) else begin
                $display("Error at %0t: out_en pulsed without an accepted beat", $time);
                fail_count = fail_count + 1;
            end
        end
        assert (finish == exp_finish) else begin
            if (finish) begin
                $display("Error at %0t: unexpected finish", $time);
            end else begin
                $display("Error at %0t: finish is low after the last pixel", $time);
            end
            fail_count = fail_count + 1;
        end
    end

    function automatic ipf_cfg_t make_cfg(input logic [1:0] mode, input int band_pos,
                                          input int o0, input int o1, input int o2,
                                          input int o3);
        ipf_cfg_t c;
        c.mode         = ipf_mode_e'(mode);
        c.band_pos     = 5'(band_pos);
        c.offsets.off0 = 4'(o0);
        c.offsets.off1 = 4'(o1);
        c.offsets.off2 = 4'(o2);
        c.offsets.off3 = 4'(o3);
        return c;
    endfunction

    function automatic ipf_cfg_t random_cfg(input logic [1:0] mode);
        return make_cfg(mode, $urandom_range(31, 0), $urandom_range(15, 0),
                        $urandom_range(15, 0), $urandom_range(15, 0), $urandom_range(15, 0));
    endfunction

    // half the pixels near the ends of the range, where clamping happens
    function automatic pixel_t biased_pixel();
        int sel;
        sel = $urandom_range(3, 0);
        if (sel == 0) begin
            return pixel_t'($urandom_range(15, 0));
        end else if (sel == 1) begin
            return pixel_t'($urandom_range(255, 240));
        end
        return pixel_t'($urandom_range(255, 0));
    endfunction

    task automatic send_beat(input pixel_t pix, input ipf_cfg_t c, input lcu_pos_t p);
        exp_t e;
        int   side;
        @(posedge clk);
        in_en <= 1'b1;
        din   <= pix;
        cfg   <= c;
        pos   <= p;
        side  = lcu_side(int'(p.lcu_size));
        e     = '0;
        e.acc = ((c.mode == IPF_OFF) || (c.mode == IPF_BAND)) && !frame_done;
        if (e.acc) begin
            e.pix  = pixel_t'(predict_pixel(int'(pix), int'(c.mode), int'(c.band_pos),
                                            c.offsets));
            e.addr = addr_t'(predict_addr(trk_row, trk_col, int'(p.lcu_x), int'(p.lcu_y),
                                          int'(p.lcu_size)));
            e.last = is_frame_last(trk_row, trk_col, int'(p.lcu_x), int'(p.lcu_y),
                                   int'(p.lcu_size));
            if (e.last) begin
                frame_done = 1'b1;
            end
            if (trk_col == side - 1) begin
                trk_col = 0;
                trk_row = (trk_row == side - 1) ? 0 : trk_row + 1;
            end else begin
                trk_col = trk_col + 1;
            end
        end
        exp_q.push_back(e);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_en <= 1'b0;
        end
    endtask

    task automatic check_idle_outputs(input string phase);
        assert (!out_en) else begin
            $display("Mismatch at %0t: out_en high %s", $time, phase);
            mismatch_count = mismatch_count + 1;
        end
        assert (!finish) else begin
            $display("Mismatch at %0t: finish high %s", $time, phase);
            mismatch_count = mismatch_count + 1;
        end
        assert (dout == '0) else begin
            $display("Mismatch at %0t: dout %0d %s, expected 0", $time, dout, phase);
            mismatch_count = mismatch_count + 1;
        end
        assert (dout_addr == '0) else begin
            $display("Mismatch at %0t: dout_addr %0d %s, expected 0", $time, dout_addr, phase);
            mismatch_count = mismatch_count + 1;
        end
    endtask

    task automatic test_reset_state();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle_outputs("during reset");
        end
        @(posedge clk);
        reset <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs("after reset");
        end
    endtask

    task automatic test_off_mode();
        lcu_pos_t p;
        p.lcu_x    = 3'd2;
        p.lcu_y    = 3'd5;
        p.lcu_size = 2'd0;
        repeat (lcu_side(0) * lcu_side(0)) begin
            send_beat(pixel_t'($urandom_range(255, 0)), random_cfg(2'd0), p);
        end
        idle_cycles(2);
    endtask

    task automatic test_band_offset();
        lcu_pos_t p;
        ipf_cfg_t c;
        int       side;
        p.lcu_x    = 3'd0;
        p.lcu_y    = 3'd2;
        p.lcu_size = 2'd1;
        side       = lcu_side(1);
        for (int r = 0; r < side; r++) begin
            // bands 0 and 31 get -8 and +7, band_pos kept away from both ends
            c = make_cfg(2'd1, $urandom_range(27, 4), -8, $urandom_range(15, 0),
                         $urandom_range(15, 0), 7);
            repeat (side) begin
                send_beat(biased_pixel(), c, p);
            end
        end
        idle_cycles(2);
    endtask

    task automatic test_ignored_modes();
        lcu_pos_t p;
        int       n;
        p.lcu_x    = 3'd0;
        p.lcu_y    = 3'd0;
        p.lcu_size = 2'd0;
        repeat (lcu_side(0) * lcu_side(0)) begin
            if ($urandom_range(3, 0) == 0) begin
                n = $urandom_range(2, 1);
                repeat (n) begin
                    send_beat(pixel_t'($urandom_range(255, 0)),
                              random_cfg(2'($urandom_range(3, 2))), p);
                end
            end
            send_beat(pixel_t'($urandom_range(255, 0)),
                      random_cfg(2'($urandom_range(1, 0))), p);
        end
        idle_cycles(2);
    endtask

    task automatic test_frame_finish();
        lcu_pos_t p;
        p.lcu_x    = 3'd1;
        p.lcu_y    = 3'd1;
        p.lcu_size = 2'd2;
        repeat (lcu_side(2) * lcu_side(2)) begin
            send_beat(biased_pixel(), random_cfg(2'($urandom_range(1, 0))), p);
        end
        idle_cycles(3);
        repeat (8) begin
            send_beat(pixel_t'($urandom_range(255, 0)), random_cfg(2'd1), p);    // all dropped
        end
        idle_cycles(4);
    endtask

    initial begin
        void'($urandom(47));
        reset          = 1'b1;
        in_en          = 1'b0;
        din            = '0;
        cfg            = '0;
        pos            = '0;
        cur_exp        = '0;
        exp_finish     = 1'b0;
        trk_row        = 0;
        trk_col        = 0;
        frame_done     = 1'b0;
        mismatch_count = 0;
        fail_count     = 0;

        test_reset_state();
        test_off_mode();
        test_band_offset();
        test_ignored_modes();
        test_frame_finish();

        repeat (4) @(posedge clk);
        $display("Test summary: %0d mismatches, %0d other errors", mismatch_count, fail_count);
        if ((mismatch_count == 0) && (fail_count == 0)) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/ipf_top.sv */
`default_nettype none

module ipf_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_en,
    input  ipf_pkg::pixel_t   din,
    input  ipf_pkg::ipf_cfg_t cfg,
    input  ipf_pkg::lcu_pos_t pos,
    output logic              out_en,
    output ipf_pkg::pixel_t   dout,
    output ipf_pkg::addr_t    dout_addr,
    output logic              finish
);
    import ipf_pkg::*;

    logic   accept;    // qualified beat, decided in the scanner only
    coord_t row;
    coord_t col;

    // beat qualification, LCU raster counters, end of frame
    ipf_lcu_scan scan_i (
        .clk    (clk),
        .reset  (reset),
        .in_en  (in_en),
        .mode   (cfg.mode),
        .pos    (pos),
        .accept (accept),
        .row    (row),
        .col    (col),
        .finish (finish)
    );

    ipf_pixel_addr addr_i (
        .clk       (clk),
        .reset     (reset),
        .accept    (accept),
        .row       (row),
        .col       (col),
        .pos       (pos),
        .dout_addr (dout_addr)
    );

    // pixel path, same latency as the address
    ipf_band_offset band_i (
        .clk    (clk),
        .reset  (reset),
        .accept (accept),
        .din    (din),
        .cfg    (cfg),
        .out_en (out_en),
        .dout   (dout)
    );

endmodule

`default_nettype wire

/* rtl/ipf_band_offset.sv */
`default_nettype none

module ipf_band_offset (
    input  logic              clk,
    input  logic              reset,
    input  logic              accept,
    input  ipf_pkg::pixel_t   din,
    input  ipf_pkg::ipf_cfg_t cfg,
    output logic              out_en,
    output ipf_pkg::pixel_t   dout
);
    import ipf_pkg::*;

    logic [BAND_W-1:0]          band;
    logic [BAND_W:0]            band_ext;    // one spare bit, range test has no wrap
    logic [BAND_W:0]            pos_ext;
    logic                       in_band;
    logic                       apply;
    logic signed [OFFSET_W-1:0] sel_off;
    logic signed [PIX_W+1:0]    sum;         // sign bit plus carry above the pixel
    pixel_t                     clamped;
    pixel_t                     pix_next;

    assign band     = din[PIX_W-1:BAND_SHIFT];
    assign band_ext = {1'b0, band};
    assign pos_ext  = {1'b0, cfg.band_pos};

    // band_pos - 1 <= band <= band_pos + 1, rearranged to stay non-negative
    assign in_band = (band_ext + 1'b1 >= pos_ext) && (band_ext <= pos_ext + 1'b1);

    assign apply = (cfg.mode == IPF_BAND) && !in_band;

    // one offset per band mod 4
    always_comb begin
        case (band[1:0])
            2'd0:    sel_off = cfg.offsets.off0;
            2'd1:    sel_off = cfg.offsets.off1;
            2'd2:    sel_off = cfg.offsets.off2;
            default: sel_off = cfg.offsets.off3;
        endcase
    end

    // offset is sign extended to the sum width
    assign sum = $signed({2'b00, din}) + sel_off;

    always_comb begin
        if (sum[PIX_W+1]) begin
            clamped = '0;                  // went below zero
        end else if (sum[PIX_W]) begin
            clamped = {PIX_W{1'b1}};       // past 255
        end else begin
            clamped = sum[PIX_W-1:0];
        end
    end

    // pixels near band_pos and mode off pass unchanged
    assign pix_next = apply ? clamped : din;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dout <= '0;
        end else if (accept) begin
            dout <= pix_next;
        end
    end

    // one cycle pulse per accepted beat
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_en <= 1'b0;
        end else begin
            out_en <= accept;
        end
    end

endmodule

`default_nettype wire

/* rtl/ipf_pixel_addr.sv */
`default_nettype none

module ipf_pixel_addr (
    input  logic              clk,
    input  logic              reset,
    input  logic              accept,
    input  ipf_pkg::coord_t   row,
    input  ipf_pkg::coord_t   col,
    input  ipf_pkg::lcu_pos_t pos,
    output ipf_pkg::addr_t    dout_addr
);
    import ipf_pkg::*;

    logic [2:0] side_log2;    // 4..6
    addr_t      frame_row;
    addr_t      frame_col;
    addr_t      addr_next;

    assign side_log2 = 3'(LCU_MIN_DIM_LOG2) + {1'b0, pos.lcu_size};

    // LCU origin in frame coordinates plus the offset inside the LCU
    assign frame_row = addr_t'(row) + (addr_t'(pos.lcu_y) << side_log2);
    assign frame_col = addr_t'(col) + (addr_t'(pos.lcu_x) << side_log2);

    // row major, 128 pixels per frame row
    assign addr_next = (frame_row << FRAME_STRIDE_LOG2) + frame_col;

    // held between beats
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dout_addr <= '0;
        end else if (accept) begin
            dout_addr <= addr_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/ipf_lcu_scan.sv */
`default_nettype none

module ipf_lcu_scan (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_en,
    input  ipf_pkg::ipf_mode_e mode,
    input  ipf_pkg::lcu_pos_t  pos,
    output logic               accept,
    output ipf_pkg::coord_t    row,
    output ipf_pkg::coord_t    col,
    output logic               finish
);
    import ipf_pkg::*;

    coord_t                side_m1;     // last row / col index in this LCU
    logic [LCU_IDX_W-1:0]  max_lcu;     // 7, 3 or 1
    logic                  mode_ok;
    logic                  col_wrap;
    logic                  row_wrap;
    logic                  last_lcu;
    logic                  last_pix;
    logic                  done;

    assign side_m1 = (coord_t'(1) << (LCU_MIN_DIM_LOG2 + pos.lcu_size)) - coord_t'(1);
    assign max_lcu = {LCU_IDX_W{1'b1}} >> pos.lcu_size;

    // modes 2 and 3 are dropped without touching the counters
    assign mode_ok = (mode == IPF_OFF) || (mode == IPF_BAND);
    assign accept  = in_en && mode_ok && !done;

    assign col_wrap = (col == side_m1);
    assign row_wrap = (row == side_m1);

    // bottom right LCU of the frame
    assign last_lcu = (pos.lcu_x == max_lcu) && (pos.lcu_y == max_lcu);
    assign last_pix = col_wrap && row_wrap && last_lcu;

    // raster walk inside the LCU
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            row <= '0;
            col <= '0;
        end else if (accept) begin
            if (col_wrap) begin
                col <= '0;
                if (row_wrap) begin
                    row <= '0;    // next LCU starts at its top left
                end else begin
                    row <= row + coord_t'(1);
                end
            end else begin
                col <= col + coord_t'(1);
            end
        end
    end

    // sticky until reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done <= 1'b0;
        end else if (accept && last_pix) begin
            done <= 1'b1;
        end
    end

    assign finish = done;    // rises with the last pixel's out_en

endmodule

`default_nettype wire

/* rtl/ipf_pkg.sv */
`default_nettype none

package ipf_pkg;

    // datapath widths
    localparam int PIX_W     = 8;
    localparam int ADDR_W    = 14;
    localparam int COORD_W   = 7;    // holds 64 - 1 in compares
    localparam int LCU_IDX_W = 3;    // lcu_x / lcu_y
    localparam int OFFSET_W  = 4;

    // frame geometry, 128 pixels per row
    localparam int FRAME_STRIDE_LOG2 = 7;
    localparam int LCU_MIN_DIM_LOG2  = 4;    // side 16 at lcu_size 0

    // band classification
    localparam int BAND_SHIFT = 3;
    localparam int BAND_W     = PIX_W - BAND_SHIFT;    // 32 bands

    typedef logic [PIX_W-1:0]   pixel_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [COORD_W-1:0] coord_t;

    // codes 2 and 3 are left unnamed, such beats are dropped
    typedef enum logic [1:0] {
        IPF_OFF  = 2'd0,
        IPF_BAND = 2'd1
    } ipf_mode_e;

    // off0 sits in the top nibble, picked when band mod 4 is 0
    typedef struct packed {
        logic signed [OFFSET_W-1:0] off0;
        logic signed [OFFSET_W-1:0] off1;
        logic signed [OFFSET_W-1:0] off2;
        logic signed [OFFSET_W-1:0] off3;
    } band_offsets_t;

    // filter setup, sampled with every pixel
    typedef struct packed {
        ipf_mode_e     mode;
        logic [BAND_W-1:0] band_pos;
        band_offsets_t offsets;
    } ipf_cfg_t;

    // lcu_size 0/1/2 -> side 16/32/64
    typedef struct packed {
        logic [LCU_IDX_W-1:0] lcu_x;
        logic [LCU_IDX_W-1:0] lcu_y;
        logic [1:0]           lcu_size;
    } lcu_pos_t;

endpackage

`default_nettype wire
